/* Makefile */
VERILATOR ?= verilator
TOP       ?= gl_top_tb
LINT_TOP  ?= gl_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j $(JOBS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/gl_top_tb.sv */
`timescale 1ns/1ps

module gl_top_tb;
    import gl_pkg::*;

    localparam VEC_FILE     = "bench/gl_vectors.txt";
    localparam CYC_PER_LINE = 40;
    localparam CYC_MARGIN   = 100;
    localparam VERTEX_WAIT  = 50;        // Cycles allowed for one vertex result

    logic    clk;
    logic    rst_n;
    logic    cmd_valid;
    opcode_t cmd_op;
    fix_t    cmd_data;
    logic    busy;
    rgb_t    color;
    logic    vertex_valid;
    vec4_t   vertex;

    int      cycles       = 0;
    int      cycle_limit  = 0;           // Set once the vector file is counted
    int      test_num     = 0;
    int      test_errs    = 0;
    int      total_errs   = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    vec4_t   vertex_q [$];

    gl_top gl_top_inst
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_data     (cmd_data),
        .busy         (busy),
        .color        (color),
        .vertex_valid (vertex_valid),
        .vertex       (vertex)
    );

    initial
        clk = 1'b0;

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the vector file did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Vertex pulses are queued so a check never misses one
    always @(negedge clk)
    begin
        if (rst_n && vertex_valid)
            vertex_q.push_back(vertex);
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic count_error();
        test_errs++;
        total_errs++;
    endtask

    task automatic report_mismatch(input string name, input fix_t expected, input fix_t actual);
        $display("Fail  t=%0t  %s expected %h got %h", $time, name, expected, actual);
        count_error();
    endtask

    // One strobe that may first wait for busy low
    task automatic send_cmd(input opcode_t op, input fix_t data, input bit wait_idle);
        if (wait_idle)
        begin
            @(negedge clk);
            while (busy)
                @(negedge clk);
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_data  <= data;
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic check_color(input fix_t red, input fix_t green, input fix_t blue);
        @(negedge clk);
        if (color.red !== red)
            report_mismatch("color.red", red, color.red);
        if (color.green !== green)
            report_mismatch("color.green", green, color.green);
        if (color.blue !== blue)
            report_mismatch("color.blue", blue, color.blue);
    endtask

    task automatic check_vertex(input fix_t ex, input fix_t ey, input fix_t ez, input fix_t ew);
        int    waited;
        vec4_t got;
        waited = 0;
        while (vertex_q.size() == 0 && waited < VERTEX_WAIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (vertex_q.size() == 0)
        begin
            $display("Error at %0t: vertex_valid did not pulse within %0d cycles",
                     $time, VERTEX_WAIT);
            count_error();
        end
        else
        begin
            got = vertex_q.pop_front();
            if (got.e0 !== ex)
                report_mismatch("vertex.e0", ex, got.e0);
            if (got.e1 !== ey)
                report_mismatch("vertex.e1", ey, got.e1);
            if (got.e2 !== ez)
                report_mismatch("vertex.e2", ez, got.e2);
            if (got.e3 !== ew)
                report_mismatch("vertex.e3", ew, got.e3);
        end
    endtask

    // Errors seen before the first test belong to test 1
    task automatic finish_test();
        if (test_num > 0)
        begin
            if (test_errs == 0)
            begin
                $display("Test %0d passed", test_num);
                tests_passed++;
            end
            else
            begin
                $display("Test %0d failed with %0d errors", test_num, test_errs);
                tests_failed++;
            end
            test_errs = 0;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int                fd;
        int                n;
        int                nlines;
        int                num;
        logic [7:0]        kind;
        logic [8*256-1:0]  line_buf;
        logic [31:0]       op_word;
        fix_t              w0;
        fix_t              w1;
        fix_t              w2;
        fix_t              w3;

        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = '0;
        cmd_data  = '0;
        nlines    = 0;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open %s for reading", VEC_FILE);
            $display("TESTBENCH FAILED");
            $finish;
        end
        else
        begin
            while ($fgets(line_buf, fd) != 0)
                nlines++;
            $fclose(fd);
            cycle_limit = CYC_PER_LINE * nlines + CYC_MARGIN;
            fd = $fopen(VEC_FILE, "r");

            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            if (busy !== 1'b0)
                report_mismatch("busy", 32'd0, {31'd0, busy});
            if (vertex_valid !== 1'b0)
                report_mismatch("vertex_valid", 32'd0, {31'd0, vertex_valid});

            while (!$feof(fd))
            begin
                n = $fscanf(fd, "%s", kind);
                if (n == 1)
                begin
                    case (kind)
                        "#":
                            n = $fgets(line_buf, fd);          // Comment line
                        "T":
                        begin
                            n = $fscanf(fd, "%d", num);
                            finish_test();
                            test_num = num;
                        end
                        "C", "B":                              // B goes out even while busy
                        begin
                            n = $fscanf(fd, "%h %h", op_word, w0);
                            send_cmd(op_word[7:0], w0, kind == "C");
                        end
                        "K":
                        begin
                            n = $fscanf(fd, "%h %h %h", w0, w1, w2);
                            check_color(w0, w1, w2);
                        end
                        "V":
                        begin
                            n = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
                            check_vertex(w0, w1, w2, w3);
                        end
                        default:
                        begin
                            $display("Error: unknown line kind in %s", VEC_FILE);
                            count_error();
                            n = $fgets(line_buf, fd);
                        end
                    endcase
                end
            end
            $fclose(fd);

            // Every vertex pulse must have been claimed by a test
            if (vertex_q.size() != 0)
            begin
                $display("Error: %0d vertex_valid pulses came that no test expected",
                         vertex_q.size());
                count_error();
            end

            finish_test();
            $display("Tests passed: %0d  tests failed: %0d  errors: %0d",
                     tests_passed, tests_failed, total_errs);
            if (total_errs == 0 && tests_failed == 0)
                $display("TESTBENCH PASSED");
            else
                $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

/* bench/gl_vectors.txt */
# T n: test start | C op data: command | B op data: command sent while busy
# K r g b: expected colour | V x y z w: expected vertex | all words hex Q16.16
T 1
K 00000000 00000000 00000000
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
V 00010000 00020000 00030000 00010000
T 2
C 04 00000000
C F0 00008000
C F0 00010000
C F0 FFFF0000
C F0 12345678
K 00008000 00010000 FFFF0000
T 3
C 13 00000000
C F0 00010000
C F0 00000000
C F0 00000000
C F0 00020000
C F0 00000000
C F0 00010000
C F0 00000000
C F0 FFFF0000
C F0 00000000
C F0 00000000
C F0 00020000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00010000
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
V 00030000 00010000 00060000 00010000
C 03 00000000
C F0 00008000
C F0 FFFE0000
C F0 00010000
C F0 00010000
V 00028000 FFFD0000 00020000 00010000
T 4
C 10 00000001
C 13 00000000
C F0 00008000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00008000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00010000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00010000
C F0 00000000
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
V 00018000 00008000 00060000 00060000
T 5
C 11 00000000
C F0 00020000
C F0 00000000
C F0 00000000
C F0 00010000
C F0 00000000
C F0 00020000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00010000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00000000
C F0 00010000
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
V 00038000 00010000 00060000 00060000
C 12 00000000
C 03 00000000
C F0 00008000
C F0 FFFE0000
C F0 00010000
C F0 00010000
V 00028000 FFFD0000 00020000 00010000
T 6
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
B 10 00000000
V 00030000 00010000 00060000 00010000
C 12 00000000
C 03 00000000
C F0 00010000
C F0 00020000
C F0 00030000
C F0 00010000
V 00030000 00010000 00060000 00010000

/* src/gl_decode.sv */
`timescale 1ns/1ps

module gl_decode
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cmd_valid,
    input  gl_pkg::opcode_t     cmd_op,
    input  gl_pkg::fix_t        cmd_data,
    input  logic                eye_valid,
    input  logic                commit,
    output logic                busy,
    output gl_pkg::rgb_t        color,
    output gl_pkg::elem_write_t elem_write,
    output logic                load_identity,
    output gl_pkg::issue_req_t  issue_req
);
    import gl_pkg::*;

    decode_state_t state;
    opcode_t       op_q;          // Command that opened the word phase
    elem_idx_t     word_cnt;      // Word index and vertex wait counter
    elem_idx_t     last_idx;
    mat_sel_t      mode;

    logic          req_valid;
    pass_t         req_pass;
    col_idx_t      req_col;

    logic          accept;
    logic          data_strobe;

    assign accept      = cmd_valid && !busy;
    assign data_strobe = accept && (cmd_op == OP_DATA) && (state == ST_WORDS);

    // Load identity acts on the matrix that mode selects
    assign load_identity = accept && (state == ST_IDLE) && (cmd_op == OP_LOADID);

    // sel follows mode for current writes, identity loads and commits
    assign issue_req = '{valid: req_valid, pass: req_pass, col: req_col, sel: mode};

    always_comb
    begin
        case (op_q)
            OP_COLOR:  last_idx = 4'd2;
            OP_VERTEX: last_idx = 4'd3;
            default:   last_idx = 4'd15;    // Both matrix loads
        endcase
    end

    //////////////////////////////////////////////////
    // Streamed words to element writes
    //////////////////////////////////////////////////

    always_comb
    begin
        elem_write.en     = data_strobe && (op_q != OP_COLOR);
        elem_write.target = TGT_CURRENT;
        case (op_q)
            OP_VERTEX:     elem_write.target = TGT_VERTEX;
            OP_MULTMATRIX: elem_write.target = TGT_OPERAND;
            default:       elem_write.target = TGT_CURRENT;
        endcase
        elem_write.index  = word_cnt;
        elem_write.data   = cmd_data;
    end

    //////////////////////////////////////////////////
    // Command FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            op_q      <= OP_DATA;
            word_cnt  <= '0;
            mode      <= 1'b0;
            busy      <= 1'b0;
            color     <= '0;
            req_valid <= 1'b0;
            req_pass  <= MV_PASS;
            req_col   <= '0;
        end
        else
        begin
            req_valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        case (cmd_op)
                            OP_MATRIXMODE:
                                mode <= cmd_data[0];
                            OP_COLOR, OP_VERTEX, OP_LOADMATRIX, OP_MULTMATRIX:
                            begin
                                op_q     <= cmd_op;
                                word_cnt <= '0;
                                state    <= ST_WORDS;
                            end
                            default: ;              // Load identity needs no state
                        endcase
                    end
                end

                ST_WORDS:
                begin
                    if (data_strobe)
                    begin
                        word_cnt <= word_cnt + 4'd1;
                        if (op_q == OP_COLOR)
                        begin
                            case (word_cnt)
                                4'd0:    color.red   <= cmd_data;
                                4'd1:    color.green <= cmd_data;
                                default: color.blue  <= cmd_data;
                            endcase
                        end
                        if (word_cnt == last_idx)
                        begin
                            case (op_q)
                                OP_VERTEX:
                                begin
                                    busy      <= 1'b1;
                                    req_valid <= 1'b1;
                                    req_pass  <= MV_PASS;
                                    req_col   <= '0;
                                    state     <= ST_WAIT_EYE;
                                end
                                OP_MULTMATRIX:
                                begin
                                    busy      <= 1'b1;
                                    req_valid <= 1'b1;  // Column 0
                                    req_pass  <= MAT_PASS;
                                    req_col   <= '0;
                                    state     <= ST_ISSUE;
                                end
                                default:
                                    state <= ST_IDLE;
                            endcase
                        end
                    end
                end

                ST_ISSUE:
                begin
                    // Columns 1 to 3 back to back
                    req_valid <= 1'b1;
                    req_col   <= req_col + 2'd1;
                    if (req_col == 2'd2)
                        state <= ST_WAIT_DONE;
                end

                ST_WAIT_EYE:
                begin
                    if (eye_valid)
                    begin
                        req_valid <= 1'b1;
                        req_pass  <= PROJ_PASS;
                        word_cnt  <= 4'd2;          // Edges until vertex_valid
                        state     <= ST_WAIT_DONE;
                    end
                end

                ST_WAIT_DONE:
                begin
                    if (req_pass == PROJ_PASS)
                    begin
                        if (word_cnt == '0)
                        begin
                            busy  <= 1'b0;          // Same edge as vertex_valid
                            state <= ST_IDLE;
                        end
                        else
                            word_cnt <= word_cnt - 4'd1;
                    end
                    else if (commit)
                    begin
                        busy  <= 1'b0;              // Matrix written on this edge
                        state <= ST_IDLE;
                    end
                end

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* src/gl_pkg.sv */
package gl_pkg;

    //////////////////////////////////////////////////
    // Fixed point format and datapath size
    //////////////////////////////////////////////////

    localparam int FRAC_BITS = 16;
    localparam int LANES     = 4;            // One lane per matrix row

    typedef logic signed [31:0] fix_t;       // Q16.16

    localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);

    typedef logic [3:0] elem_idx_t;          // Row in the upper two bits
    typedef logic [1:0] col_idx_t;
    typedef logic [7:0] opcode_t;
    typedef logic       mat_sel_t;           // 0 modelview, 1 projection

    typedef struct packed {
        fix_t e0;
        fix_t e1;
        fix_t e2;
        fix_t e3;
    } vec4_t;

    typedef struct packed {
        vec4_t r0;
        vec4_t r1;
        vec4_t r2;
        vec4_t r3;
    } mat4_t;

    typedef struct packed {
        fix_t red;
        fix_t green;
        fix_t blue;
    } rgb_t;

    //////////////////////////////////////////////////
    // Command opcodes
    //////////////////////////////////////////////////

    localparam opcode_t OP_VERTEX     = 8'h03;
    localparam opcode_t OP_COLOR      = 8'h04;
    localparam opcode_t OP_MATRIXMODE = 8'h10;
    localparam opcode_t OP_MULTMATRIX = 8'h11;
    localparam opcode_t OP_LOADID     = 8'h12;
    localparam opcode_t OP_LOADMATRIX = 8'h13;
    localparam opcode_t OP_DATA       = 8'hF0;   // Operand word

    typedef enum logic [1:0] {
        MV_PASS,
        PROJ_PASS,
        MAT_PASS
    } pass_t;

    typedef enum logic [1:0] {
        TGT_CURRENT,
        TGT_OPERAND,
        TGT_VERTEX
    } wr_target_t;

    typedef struct packed {
        logic       en;
        wr_target_t target;
        elem_idx_t  index;
        fix_t       data;
    } elem_write_t;

    typedef struct packed {
        logic     valid;
        pass_t    pass;
        col_idx_t col;
        mat_sel_t sel;
    } issue_req_t;

    typedef struct packed {
        logic     valid;
        pass_t    pass;
        col_idx_t col;
    } issue_t;

    typedef struct packed {
        logic     valid;
        pass_t    pass;
        col_idx_t col;
        fix_t     value;
    } lane_out_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WORDS,
        ST_ISSUE,
        ST_WAIT_EYE,
        ST_WAIT_DONE
    } decode_state_t;

    //////////////////////////////////////////////////
    // Element access with e0 and r0 in the top bits
    //////////////////////////////////////////////////

    function automatic fix_t vec_get(vec4_t v, col_idx_t i);
        return v[(3 - int'(i)) * 32 +: 32];
    endfunction

    function automatic vec4_t vec_put(vec4_t v, col_idx_t i, fix_t d);
        vec4_t r;
        r = v;
        r[(3 - int'(i)) * 32 +: 32] = d;
        return r;
    endfunction

    function automatic fix_t mat_get(mat4_t m, elem_idx_t k);
        return m[(15 - int'(k)) * 32 +: 32];
    endfunction

    function automatic mat4_t mat_put(mat4_t m, elem_idx_t k, fix_t d);
        mat4_t r;
        r = m;
        r[(15 - int'(k)) * 32 +: 32] = d;
        return r;
    endfunction

    function automatic vec4_t mat_row(mat4_t m, col_idx_t r);
        return m[(3 - int'(r)) * 128 +: 128];
    endfunction

    function automatic vec4_t mat_col(mat4_t m, col_idx_t c);
        vec4_t v;
        v = '0;
        for (int i = 0; i < 4; i++)
        begin
            v = vec_put(v, col_idx_t'(i), mat_get(m, {col_idx_t'(i), c}));
        end
        return v;
    endfunction

    function automatic mat4_t mat_identity();
        mat4_t m;
        m = '0;
        for (int i = 0; i < 4; i++)
        begin
            m = mat_put(m, {col_idx_t'(i), col_idx_t'(i)}, FIX_ONE);
        end
        return m;
    endfunction

endpackage

/* src/gl_top.sv */
`timescale 1ns/1ps

module gl_top
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_valid,
    input  gl_pkg::opcode_t cmd_op,
    input  gl_pkg::fix_t    cmd_data,
    output logic            busy,
    output gl_pkg::rgb_t    color,
    output logic            vertex_valid,
    output gl_pkg::vec4_t   vertex
);
    import gl_pkg::*;

    elem_write_t elem_write;
    logic        load_identity;
    issue_req_t  issue_req;

    issue_t      issue;
    vec4_t       column;
    vec4_t       rows [LANES];
    lane_out_t   results [LANES];

    logic        eye_valid;
    vec4_t       eye;
    logic        commit;
    mat4_t       product;

    gl_decode gl_decode_inst
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_data      (cmd_data),
        .eye_valid     (eye_valid),
        .commit        (commit),
        .busy          (busy),
        .color         (color),
        .elem_write    (elem_write),
        .load_identity (load_identity),
        .issue_req     (issue_req)
    );

    matrix_regs matrix_regs_inst
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .elem_write    (elem_write),
        .load_identity (load_identity),
        .issue_req     (issue_req),
        .eye           (eye),
        .commit        (commit),
        .product       (product),
        .issue         (issue),
        .column        (column),
        .rows          (rows)
    );

    //////////////////////////////////////////////////
    // One dot product lane per matrix row
    //////////////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++)
    begin : g_lane
        row_dot row_dot_inst
        (
            .clk    (clk),
            .rst_n  (rst_n),
            .issue  (issue),
            .row    (rows[i]),
            .column (column),
            .result (results[i])
        );
    end

    matrix_collect matrix_collect_inst
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .results      (results),
        .eye_valid    (eye_valid),
        .eye          (eye),
        .vertex_valid (vertex_valid),
        .vertex       (vertex),
        .commit       (commit),
        .product      (product)
    );

endmodule

/* src/matrix_collect.sv */
`timescale 1ns/1ps

module matrix_collect
(
    input  logic              clk,
    input  logic              rst_n,
    input  gl_pkg::lane_out_t results [gl_pkg::LANES],
    output logic              eye_valid,
    output gl_pkg::vec4_t     eye,
    output logic              vertex_valid,
    output gl_pkg::vec4_t     vertex,
    output logic              commit,
    output gl_pkg::mat4_t     product
);
    import gl_pkg::*;

    vec4_t lane_vec;
    mat4_t product_next;
    logic  res_valid;
    pass_t res_pass;

    // All lanes carry the same tag
    assign res_valid = results[0].valid;
    assign res_pass  = results[0].pass;

    always_comb
    begin
        lane_vec     = '0;
        product_next = product;
        for (int i = 0; i < LANES; i++)
        begin
            lane_vec     = vec_put(lane_vec, col_idx_t'(i), results[i].value);
            product_next = mat_put(product_next, {col_idx_t'(i), results[0].col},
                                   results[i].value);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            eye_valid    <= 1'b0;
            vertex_valid <= 1'b0;
            commit       <= 1'b0;
        end
        else
        begin
            eye_valid    <= res_valid && res_pass == MV_PASS;
            vertex_valid <= res_valid && res_pass == PROJ_PASS;
            commit       <= res_valid && res_pass == MAT_PASS && results[0].col == 2'd3;
        end
        if (res_valid && res_pass == MV_PASS)
            eye <= lane_vec;
        if (res_valid && res_pass == PROJ_PASS)
            vertex <= lane_vec;
        if (res_valid && res_pass == MAT_PASS)
            product <= product_next;        // One column per result
    end

endmodule

/* src/matrix_regs.sv */
`timescale 1ns/1ps

module matrix_regs
(
    input  logic                clk,
    input  logic                rst_n,
    input  gl_pkg::elem_write_t elem_write,
    input  logic                load_identity,
    input  gl_pkg::issue_req_t  issue_req,
    input  gl_pkg::vec4_t       eye,
    input  logic                commit,
    input  gl_pkg::mat4_t       product,
    output gl_pkg::issue_t      issue,
    output gl_pkg::vec4_t       column,
    output gl_pkg::vec4_t       rows [gl_pkg::LANES]
);
    import gl_pkg::*;

    mat4_t modelview;
    mat4_t projection;
    mat4_t operand;               // Right-hand matrix of a multiply
    vec4_t vertex_reg;

    mat4_t cur_mat;
    mat4_t cur_next;
    mat4_t row_src;
    vec4_t col_src;

    assign cur_mat = issue_req.sel ? projection : modelview;

    //////////////////////////////////////////////////
    // Current matrix update
    //////////////////////////////////////////////////

    always_comb
    begin
        cur_next = cur_mat;
        if (commit)
            cur_next = product;
        else if (load_identity)
            cur_next = mat_identity();
        else if (elem_write.en && elem_write.target == TGT_CURRENT)
            cur_next = mat_put(cur_mat, elem_write.index, elem_write.data);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            modelview  <= mat_identity();
            projection <= mat_identity();
        end
        else if (issue_req.sel)
            projection <= cur_next;
        else
            modelview  <= cur_next;
    end

    always_ff @(posedge clk)
    begin
        if (elem_write.en && elem_write.target == TGT_OPERAND)
            operand <= mat_put(operand, elem_write.index, elem_write.data);
        if (elem_write.en && elem_write.target == TGT_VERTEX)
            vertex_reg <= vec_put(vertex_reg, elem_write.index[1:0], elem_write.data);
    end

    //////////////////////////////////////////////////
    // Operand select for the lanes
    //////////////////////////////////////////////////

    always_comb
    begin
        case (issue_req.pass)
            MAT_PASS:
            begin
                row_src = cur_mat;
                col_src = mat_col(operand, issue_req.col);
            end
            MV_PASS:
            begin
                row_src = modelview;
                col_src = vertex_reg;
            end
            default:
            begin
                row_src = projection;   // Eye vector back through projection
                col_src = eye;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            issue.valid <= 1'b0;
        else
            issue.valid <= issue_req.valid;
        issue.pass <= issue_req.pass;
        issue.col  <= issue_req.col;
        column     <= col_src;
        for (int r = 0; r < LANES; r++)
        begin
            rows[r] <= mat_row(row_src, col_idx_t'(r));
        end
    end

endmodule

/* src/row_dot.sv */
`timescale 1ns/1ps

module row_dot
(
    input  logic              clk,
    input  logic              rst_n,
    input  gl_pkg::issue_t    issue,
    input  gl_pkg::vec4_t     row,
    input  gl_pkg::vec4_t     column,
    output gl_pkg::lane_out_t result
);
    import gl_pkg::*;

    logic signed [63:0] prod [4];     // Full products
    fix_t               term [4];
    fix_t               sum;

    always_comb
    begin
        sum = '0;
        for (int i = 0; i < 4; i++)
        begin
            prod[i] = 64'(vec_get(row, col_idx_t'(i))) * 64'(vec_get(column, col_idx_t'(i)));
            term[i] = fix_t'(prod[i] >>> FRAC_BITS);   // Back to Q16.16
            sum     = sum + term[i];                    // Wraps at 32 bits
        end
    end

    // New column accepted every cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            result.valid <= 1'b0;
        else
            result.valid <= issue.valid;
        result.pass  <= issue.pass;
        result.col   <= issue.col;
        result.value <= sum;
    end

endmodule

/* verilog.f */
src/gl_pkg.sv
src/row_dot.sv
src/matrix_regs.sv
src/matrix_collect.sv
src/gl_decode.sv
src/gl_top.sv
bench/gl_top_tb.sv
